//--- hw/camera_pkg.sv
package camera_pkg;

  // decoded key packet, strobes first then one held bit per movement key
  typedef struct packed {
    logic pressed;
    logic released;
    logic d;
    logic a;
    logic e;
    logic q;
    logic w;
    logic s;
  } keys_t;

  typedef logic signed [15:0] coord_t;

  // eye position, x in the top bits
  typedef struct packed {
    coord_t x;
    coord_t y;
    coord_t z;
  } vector_t;

  typedef logic [2:0] key_idx_t;

  // movement index, axis and sign
  localparam key_idx_t KEY_D = 3'd0;  // x minus
  localparam key_idx_t KEY_A = 3'd1;  // x plus
  localparam key_idx_t KEY_E = 3'd2;  // y plus
  localparam key_idx_t KEY_Q = 3'd3;  // y minus
  localparam key_idx_t KEY_W = 3'd4;  // z plus
  localparam key_idx_t KEY_S = 3'd5;  // z minus

  // set 2 make codes
  localparam logic [7:0] SC_D     = 8'h23;
  localparam logic [7:0] SC_A     = 8'h1C;
  localparam logic [7:0] SC_E     = 8'h24;
  localparam logic [7:0] SC_Q     = 8'h15;
  localparam logic [7:0] SC_W     = 8'h1D;
  localparam logic [7:0] SC_S     = 8'h1B;
  localparam logic [7:0] SC_BREAK = 8'hF0;

endpackage

//--- hw/ps2_key_decoder.sv
`timescale 1ns/1ps

module ps2_key_decoder (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              scan_valid,
  input  logic [7:0]        scan_code,
  output camera_pkg::keys_t keys
);

  import camera_pkg::*;

  logic       brk_pend;
  logic [5:0] held;
  logic       press_q;
  logic       release_q;
  logic       map_hit;
  key_idx_t   map_idx;

  // scan code to movement index
  always_comb begin
    map_hit = 1'b1;
    map_idx = KEY_D;
    case (scan_code)
      SC_D:    map_idx = KEY_D;
      SC_A:    map_idx = KEY_A;
      SC_E:    map_idx = KEY_E;
      SC_Q:    map_idx = KEY_Q;
      SC_W:    map_idx = KEY_W;
      SC_S:    map_idx = KEY_S;
      default: map_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      brk_pend  <= 1'b0;
      held      <= '0;
      press_q   <= 1'b0;
      release_q <= 1'b0;
    end else begin
      press_q   <= 1'b0;
      release_q <= 1'b0;
      if (scan_valid) begin
        if (scan_code == SC_BREAK) begin
          brk_pend <= 1'b1;
        end else begin
          // any other byte ends a break sequence
          brk_pend <= 1'b0;
          if (map_hit) begin
            if (brk_pend) begin
              // only a held key can be released
              if (held[map_idx]) begin
                held[map_idx] <= 1'b0;
                release_q     <= 1'b1;
              end
            end else if (!held[map_idx]) begin
              held[map_idx] <= 1'b1;
              // chord keys are recorded silently
              press_q       <= (held == '0);
            end
          end
        end
      end
    end
  end

  assign keys = '{pressed:  press_q,
                  released: release_q,
                  d:        held[KEY_D],
                  a:        held[KEY_A],
                  e:        held[KEY_E],
                  q:        held[KEY_Q],
                  w:        held[KEY_W],
                  s:        held[KEY_S]};

  a_strobe_excl: assert property (@(posedge clk) disable iff (!arst_n)
    !(keys.pressed && keys.released));

endmodule

//--- hw/camera_controller.sv
`timescale 1ns/1ps

module camera_controller (
  input  logic                 clk,
  input  logic                 arst_n,
  input  camera_pkg::keys_t    keys,
  input  logic                 frame_tick,
  input  logic                 rendering_done,
  output logic                 render_frame,
  output camera_pkg::key_idx_t key,
  output logic [31:0]          step_cnt
);

  import camera_pkg::*;

  typedef enum logic [1:0] {K_IDLE, K_PRESSED, K_FINISHING} key_state_t;
  typedef enum logic [1:0] {R_IDLE, R_HOLD, R_LAST, R_DRAIN} req_state_t;

  key_state_t  key_st, key_st_n;
  req_state_t  req_st, req_st_n;
  logic        held_st;
  logic        ld_key;
  key_idx_t    key_n;
  logic        busy;
  logic        counting;
  logic [31:0] cnt;
  logic        start_cnt0, start_cnt25, stop_cnt, clr_cnt;

  assign held_st = (key_st == K_PRESSED);
  assign ld_key  = (key_st == K_IDLE) && keys.pressed;

  // key machine, follows the lone movement key
  always_comb begin
    key_st_n = key_st;
    case (key_st)
      K_IDLE:      if (keys.pressed) key_st_n = K_PRESSED;
      K_PRESSED:   if (keys.released) key_st_n = K_FINISHING;
      K_FINISHING: if (!busy) key_st_n = K_IDLE;
      default:     key_st_n = K_IDLE;
    endcase
  end

  // one-hot held bits to index
  always_comb begin
    key_n = key;
    if (ld_key) begin
      case ({keys.d, keys.a, keys.e, keys.q, keys.w, keys.s})
        6'b100000: key_n = KEY_D;
        6'b010000: key_n = KEY_A;
        6'b001000: key_n = KEY_E;
        6'b000100: key_n = KEY_Q;
        6'b000010: key_n = KEY_W;
        6'b000001: key_n = KEY_S;
        default:   key_n = key;
      endcase
    end
  end

  // request machine
  always_comb begin
    req_st_n     = req_st;
    render_frame = 1'b0;
    start_cnt0   = 1'b0;
    start_cnt25  = 1'b0;
    stop_cnt     = 1'b0;
    clr_cnt      = 1'b0;
    case (req_st)
      R_IDLE: begin
        if (held_st) req_st_n = R_HOLD;
        start_cnt0   = held_st;
        render_frame = held_st && !busy;
      end
      R_HOLD: begin
        if (!held_st) req_st_n = R_LAST;
        stop_cnt     = !held_st;
        render_frame = held_st && !busy;
        start_cnt25  = held_st && !busy;
      end
      R_LAST: begin
        // one closing request once the renderer is free
        if (!busy) req_st_n = R_DRAIN;
        render_frame = !busy;
      end
      R_DRAIN: begin
        if (held_st) req_st_n = R_HOLD;
        else if (!busy) req_st_n = R_IDLE;
        start_cnt0   = held_st;
        clr_cnt      = !held_st && !busy;
        render_frame = held_st && !busy;
      end
      default: req_st_n = R_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      key_st   <= K_IDLE;
      req_st   <= R_IDLE;
      key      <= KEY_D;
      busy     <= 1'b0;
      counting <= 1'b0;
      cnt      <= '0;
    end else begin
      key_st <= key_st_n;
      req_st <= req_st_n;
      key    <= key_n;
      // done wins over a new request
      if (rendering_done) busy <= 1'b0;
      else if (render_frame) busy <= 1'b1;
      if (stop_cnt) counting <= 1'b0;
      else if (start_cnt0 || start_cnt25) counting <= 1'b1;
      // hold length, +3 per frame
      if (clr_cnt || start_cnt0) cnt <= '0;
      else if (start_cnt25) cnt <= 32'd25;
      else if (!stop_cnt && frame_tick && counting) cnt <= cnt + 32'd3;
    end
  end

  assign step_cnt = cnt;

  a_no_req_busy: assert property (@(posedge clk) disable iff (!arst_n)
    busy |-> !render_frame);

  a_key_range: assert property (@(posedge clk) disable iff (!arst_n)
    key < 3'd6);

endmodule

//--- hw/camera_datapath.sv
`timescale 1ns/1ps

module camera_datapath #(
  parameter int                  MAX_STEP = 96,
  parameter camera_pkg::vector_t HOME     = '0
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 load,
  input  camera_pkg::key_idx_t key,
  input  logic [31:0]          step_cnt,
  output camera_pkg::vector_t  eye
);

  import camera_pkg::*;

  coord_t  step;
  vector_t eye_n;

  // clamp to the per-frame limit
  assign step = (step_cnt > 32'(MAX_STEP)) ? coord_t'(MAX_STEP) : coord_t'(step_cnt[15:0]);

  always_comb begin
    eye_n = eye;
    case (key)
      KEY_D:   eye_n.x = eye.x - step;
      KEY_A:   eye_n.x = eye.x + step;
      KEY_E:   eye_n.y = eye.y + step;
      KEY_Q:   eye_n.y = eye.y - step;
      KEY_W:   eye_n.z = eye.z + step;
      KEY_S:   eye_n.z = eye.z - step;
      default: eye_n = eye;
    endcase
  end

  // coordinates wrap at 16 bits
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      eye <= HOME;
    end else if (load) begin
      eye <= eye_n;
    end
  end

  a_eye_on_load: assert property (@(posedge clk) disable iff (!arst_n)
    !$stable(eye) |-> $past(load));

endmodule

//--- hw/camera_top.sv
`timescale 1ns/1ps

module camera_top #(
  parameter int                  MAX_STEP = 96,
  parameter camera_pkg::vector_t HOME     = '{x: 16'sd0, y: 16'sd0, z: -16'sd256}
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                scan_valid,
  input  logic [7:0]          scan_code,
  input  logic                frame_tick,
  input  logic                rendering_done,
  output logic                render_frame,
  output camera_pkg::vector_t eye
);

  import camera_pkg::*;

  keys_t       keys;
  key_idx_t    key;
  logic [31:0] step_cnt;

  ps2_key_decoder u_decoder (
    .clk        (clk),
    .arst_n     (arst_n),
    .scan_valid (scan_valid),
    .scan_code  (scan_code),
    .keys       (keys)
  );

  camera_controller u_controller (
    .clk            (clk),
    .arst_n         (arst_n),
    .keys           (keys),
    .frame_tick     (frame_tick),
    .rendering_done (rendering_done),
    .render_frame   (render_frame),
    .key            (key),
    .step_cnt       (step_cnt)
  );

  // the render request doubles as the eye load
  camera_datapath #(
    .MAX_STEP (MAX_STEP),
    .HOME     (HOME)
  ) u_datapath (
    .clk      (clk),
    .arst_n   (arst_n),
    .load     (render_frame),
    .key      (key),
    .step_cnt (step_cnt),
    .eye      (eye)
  );

endmodule

//--- sim/camera_checker.sv
`timescale 1ns/1ps

module camera_checker (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                render_frame,
  input  logic                rendering_done,
  input  camera_pkg::vector_t eye,
  input  camera_pkg::vector_t home,
  input  int                  max_step,
  input  logic                quiet,
  input  int                  test_idx,
  input  logic [1:0]          exp_axis,
  input  logic                exp_sign,
  input  logic                check_end,
  input  camera_pkg::vector_t exp_eye,
  input  int                  exp_renders,
  output int                  errors
);

  import camera_pkg::*;

  vector_t last_eye;
  logic    last_load;
  logic    last_first;
  logic    outstanding;
  logic    just_reset;
  int      renders;
  int      last_idx;

  initial errors = 0;

  task automatic report_value(input string name, input int exp_v, input int got_v);
    errors++;
    $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp_v, got_v);
  endtask

  task automatic report_text(input string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  function automatic int coord_of(input vector_t v, input int ax);
    case (ax)
      0:       return int'(v.x);
      1:       return int'(v.y);
      default: return int'(v.z);
    endcase
  endfunction

  function automatic string axis_name(input int ax);
    case (ax)
      0:       return "eye.x";
      1:       return "eye.y";
      default: return "eye.z";
    endcase
  endfunction

  // the clamp, or +3 per tick with an optional restart at 25
  function automatic logic step_allowed(input int mag);
    return (mag == max_step) || (mag % 3 == 0) ||
           (mag >= 25 && (mag - 25) % 3 == 0);
  endfunction

  task automatic check_step();
    int d;
    int mag;
    for (int ax = 0; ax < 3; ax++) begin
      d = int'(coord_t'(coord_of(eye, ax) - coord_of(last_eye, ax)));
      if (ax != int'(exp_axis)) begin
        if (d != 0) report_value(axis_name(ax), 0, d);
      end else begin
        mag = exp_sign ? d : -d;
        if (last_first && mag != 0) begin
          report_value(axis_name(ax), 0, mag);
        end else if (!last_first && mag == 0) begin
          report_text($sformatf("%s did not move on a repeat request", axis_name(ax)));
        end else if (mag < 0 || mag > max_step) begin
          report_value(axis_name(ax), max_step, mag);
        end else if (!step_allowed(mag)) begin
          report_text($sformatf("%s step of %0d fits no hold count", axis_name(ax), mag));
        end
      end
    end
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding = 1'b0;
      last_load   = 1'b0;
      last_first  = 1'b0;
      renders     = 0;
      last_idx    = 0;
      just_reset  = 1'b1;
    end else begin
      if (just_reset) begin
        for (int ax = 0; ax < 3; ax++) begin
          if (coord_of(eye, ax) != coord_of(home, ax))
            report_value(axis_name(ax), coord_of(home, ax), coord_of(eye, ax));
        end
      end else if (last_load) begin
        check_step();
      end else if (eye != last_eye) begin
        report_text("eye changed without a render request");
      end
      just_reset = 1'b0;
      if (test_idx != last_idx) begin
        renders  = 0;
        last_idx = test_idx;
      end
      last_first = render_frame && (renders == 0);
      if (render_frame) begin
        if (outstanding) report_text("render_frame raised while a render was outstanding");
        if (quiet) report_text("render_frame raised with no movement key pressed");
        renders++;
        outstanding = 1'b1;
      end
      if (rendering_done) outstanding = 1'b0;
      if (check_end) begin
        for (int ax = 0; ax < 3; ax++) begin
          if (coord_of(eye, ax) != coord_of(exp_eye, ax))
            report_value(axis_name(ax), coord_of(exp_eye, ax), coord_of(eye, ax));
        end
        if (renders != exp_renders) report_value("render_frame count", exp_renders, renders);
      end
      last_eye  = eye;
      last_load = render_frame;
    end
  end

endmodule

//--- sim/camera_tb.sv
`timescale 1ns/1ps

module camera_tb;

  import camera_pkg::*;

  localparam int WAIT_LIMIT = 2000;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        scan_valid;
  logic [7:0]  scan_code;
  logic        frame_tick;
  logic        rendering_done;
  logic        render_frame;
  vector_t     eye;
  vector_t     home;
  int          max_step;
  logic        quiet;
  logic        check_end;
  int          test_idx;
  int          exp_renders;
  logic [1:0]  exp_axis;
  logic        exp_sign;
  vector_t     exp_eye;
  int          checker_errors;
  int          tb_errors = 0;
  logic        abort = 1'b0;
  int          render_cnt = 0;
  logic        rend_active = 1'b0;
  int          cur_ticks = 0;
  int          gap;
  logic [31:0] rng = 32'h1e6b0434;
  int          fd;
  string       line;
  int          fields;
  logic [7:0]  pre0, pre1, pre2, key_code, ext0, ext1;
  int          holds, ticks, axis, sign, ex, ey, ez;

  always #20 clk = ~clk;

  assign home     = u_camera_top.HOME;
  assign max_step = u_camera_top.MAX_STEP;

  camera_top u_camera_top (
    .clk            (clk),
    .arst_n         (arst_n),
    .scan_valid     (scan_valid),
    .scan_code      (scan_code),
    .frame_tick     (frame_tick),
    .rendering_done (rendering_done),
    .render_frame   (render_frame),
    .eye            (eye)
  );

  camera_checker u_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .render_frame   (render_frame),
    .rendering_done (rendering_done),
    .eye            (eye),
    .home           (home),
    .max_step       (max_step),
    .quiet          (quiet),
    .test_idx       (test_idx),
    .exp_axis       (exp_axis),
    .exp_sign       (exp_sign),
    .check_end      (check_end),
    .exp_eye        (exp_eye),
    .exp_renders    (exp_renders),
    .errors         (checker_errors)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // renderer model, frame ticks while busy, then done after 1 to 12 cycles
  always @(posedge clk) begin
    if (arst_n && render_frame) begin
      render_cnt++;
      rend_active = 1'b1;
      rng = xorshift32(rng);
      gap = int'(rng % 12) + 1;
      for (int i = 0; i < cur_ticks + gap; i++) begin
        @(negedge clk);
        frame_tick     = (i < cur_ticks);
        rendering_done = (i == cur_ticks + gap - 1);
      end
      @(negedge clk);
      frame_tick     = 1'b0;
      rendering_done = 1'b0;
      rend_active    = 1'b0;
    end
  end

  // called on a falling edge, bytes go out back to back
  task automatic send_byte(input logic [7:0] b);
    scan_valid = 1'b1;
    scan_code  = b;
    @(negedge clk);
    scan_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_renders(input int target);
    int cnt;
    cnt = 0;
    while (render_cnt < target && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (render_cnt < target) begin
      $display("ERROR t=%0t timed out waiting for render request %0d", $time, target);
      tb_errors++;
      abort = 1'b1;
    end
  endtask

  task automatic wait_render_idle();
    int cnt;
    cnt = 0;
    while (rend_active && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (rend_active) begin
      $display("ERROR t=%0t timed out waiting for the renderer to finish", $time);
      tb_errors++;
      abort = 1'b1;
    end
  endtask

  task automatic run_test();
    int base;
    if (pre0 != 8'h00) send_byte(pre0);
    if (pre1 != 8'h00) send_byte(pre1);
    if (pre2 != 8'h00) send_byte(pre2);
    idle_cycles(3);
    test_idx++;
    exp_axis  = axis[1:0];
    exp_sign  = sign[0];
    cur_ticks = ticks;
    quiet     = 1'b0;
    base      = render_cnt;
    send_byte(key_code);
    wait_renders(base + 1);
    if (abort) return;
    // chord or typematic bytes while the key is held
    if (ext0 != 8'h00) send_byte(ext0);
    if (ext1 != 8'h00) send_byte(ext1);
    wait_renders(base + holds);
    if (abort) return;
    send_byte(SC_BREAK);
    send_byte(key_code);
    wait_renders(base + holds + 1);
    if (abort) return;
    wait_render_idle();
    if (abort) return;
    idle_cycles(4);
    exp_eye     = '{x: coord_t'(ex), y: coord_t'(ey), z: coord_t'(ez)};
    exp_renders = holds + 1;
    check_end   = 1'b1;
    @(negedge clk);
    check_end = 1'b0;
    quiet     = 1'b1;
    if (ext0 != 8'h00) begin
      send_byte(SC_BREAK);
      send_byte(ext0);
    end
    if (ext1 != 8'h00) begin
      send_byte(SC_BREAK);
      send_byte(ext1);
    end
    idle_cycles(3);
  endtask

  initial begin
    arst_n         = 1'b0;
    scan_valid     = 1'b0;
    scan_code      = 8'h00;
    frame_tick     = 1'b0;
    rendering_done = 1'b0;
    quiet          = 1'b1;
    check_end      = 1'b0;
    test_idx       = 0;
    exp_renders    = 0;
    exp_axis       = 2'd0;
    exp_sign       = 1'b0;
    exp_eye        = '0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    idle_cycles(4);
    fd = $fopen("sim/camera_tests.txt", "r");
    if (fd == 0) begin
      $display("ERROR could not open the tests file");
      tb_errors++;
      abort = 1'b1;
    end else begin
      while (!$feof(fd) && !abort) begin
        if ($fgets(line, fd) != 0 && line.len() > 4 && line.getc(0) != 8'h23) begin
          fields = $sscanf(line, "%h %h %h %h %h %h %d %d %d %d %d %d %d", pre0, pre1,
                           pre2, key_code, ext0, ext1, holds, ticks, axis, sign, ex, ey, ez);
          if (fields == 13) run_test();
        end
      end
      $fclose(fd);
    end
    idle_cycles(2);
    $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
    if (checker_errors == 0 && tb_errors == 0 && !abort) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sim/camera_tests.txt
# pre0 pre1 pre2 key ext0 ext1 (hex scan codes, 00 = none) then holds ticks (decimal)
# axis (0 x, 1 y, 2 z) sign (1 plus, 0 minus) and final eye x y z (decimal)
00 00 00 23 00 00 1 2 0 0 -6 0 -256
F0 1C 00 1C 00 00 3 4 0 1 77 0 -256
29 F0 29 24 1C 24 2 5 1 1 77 49 -256
00 00 00 15 00 00 4 30 1 0 77 -267 -256
00 00 00 1D 1B 00 2 3 2 1 77 -267 -213
F0 23 00 1B 00 00 5 40 2 0 77 -267 -631
00 00 00 23 00 00 1 3 0 0 68 -267 -631
00 00 00 24 24 24 3 24 1 1 68 -65 -631

//--- camera.f
hw/camera_pkg.sv
hw/ps2_key_decoder.sv
hw/camera_controller.sv
hw/camera_datapath.sv
hw/camera_top.sv
sim/camera_checker.sv
sim/camera_tb.sv

//--- Bender.yml
package:
  name: camera

sources:
  - hw/camera_pkg.sv
  - hw/ps2_key_decoder.sv
  - hw/camera_controller.sv
  - hw/camera_datapath.sv
  - hw/camera_top.sv
  - target: simulation
    files:
      - sim/camera_checker.sv
      - sim/camera_tb.sv
